/* ram_writer_defines.svh */
`ifndef RAM_WRITER_DEFINES_SVH
`define RAM_WRITER_DEFINES_SVH

// Stream and memory bus widths
`define RW_AXIS_WIDTH      32
`define RW_AXI_DATA_WIDTH  64
`define RW_AXI_ADDR_WIDTH  32
`define RW_AXI_ID_WIDTH    6
`define RW_AXI_STRB_WIDTH  (`RW_AXI_DATA_WIDTH / 8)

// Fixed INCR burst, 16 beats of 8 bytes
`define RW_BURST_LEN       16
`define RW_BURST_BYTES     (`RW_BURST_LEN * `RW_AXI_STRB_WIDTH)
`define RW_AXI_SIZE        3'd3

// Beat FIFO geometry
`define RW_FIFO_DEPTH      32
`define RW_FIFO_PTR_WIDTH  5
`define RW_FIFO_CNT_WIDTH  6

// Register map
`define RW_LITE_ADDR_WIDTH 5
`define RW_LITE_DATA_WIDTH 32
`define RW_REG_CTRL        5'h00
`define RW_REG_BASE        5'h04
`define RW_REG_SIZE        5'h08
`define RW_REG_PTR         5'h0C
`define RW_REG_ERR         5'h10

`endif

/* ram_writer_pkg.sv */
`include "ram_writer_defines.svh"

package ram_writer_pkg;

  // AXI response codes
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [`RW_AXI_ID_WIDTH-1:0]   id;
    logic [`RW_AXI_ADDR_WIDTH-1:0] addr;
    logic [7:0]                    len;
    logic [2:0]                    size;
    logic [1:0]                    burst;
    logic [3:0]                    cache;
    logic [2:0]                    prot;
  } axi_aw_t;

  typedef struct packed {
    logic [`RW_AXI_DATA_WIDTH-1:0] data;
    logic [`RW_AXI_STRB_WIDTH-1:0] strb;
    logic                          last;
  } axi_w_t;

  typedef struct packed {
    logic [`RW_AXI_ID_WIDTH-1:0] id;
    logic [1:0]                  resp;
  } axi_b_t;

  typedef struct packed {
    logic [`RW_LITE_ADDR_WIDTH-1:0] addr;
  } lite_aw_t;

  typedef struct packed {
    logic [`RW_LITE_DATA_WIDTH-1:0]   data;
    logic [`RW_LITE_DATA_WIDTH/8-1:0] strb;
  } lite_w_t;

  typedef struct packed {
    logic [`RW_LITE_ADDR_WIDTH-1:0] addr;
  } lite_ar_t;

  typedef struct packed {
    logic [`RW_LITE_DATA_WIDTH-1:0] data;
    logic [1:0]                     resp;
  } lite_r_t;

  typedef struct packed {
    logic        enable;
    logic [31:0] base;
    logic [31:0] size;  // Ring size in bytes
  } rw_cfg_t;

  typedef struct packed {
    logic [31:0] ptr;  // Offset after last acknowledged burst
    logic [31:0] err_count;
  } rw_status_t;

endpackage

/* axis_pack_fifo.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module axis_pack_fifo (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  ram_writer_pkg::rw_cfg_t       cfg,
  input  logic [`RW_AXIS_WIDTH-1:0]     tdata,
  input  logic                          tvalid,
  output logic                          tready,
  output logic [`RW_AXI_DATA_WIDTH-1:0] beat,
  output logic                          beat_valid,
  input  logic                          beat_ready,
  output logic [`RW_FIFO_CNT_WIDTH-1:0] beat_count
);

  logic [`RW_AXIS_WIDTH-1:0]     half_q;      // First word of the pair
  logic                          half_valid;
  logic [`RW_AXI_DATA_WIDTH-1:0] mem [`RW_FIFO_DEPTH];
  logic [`RW_FIFO_PTR_WIDTH-1:0] wr_ptr;
  logic [`RW_FIFO_PTR_WIDTH-1:0] rd_ptr;
  logic [`RW_FIFO_CNT_WIDTH-1:0] count;
  logic                          word_hs;
  logic                          push;
  logic                          pop;

  assign tready     = cfg.enable && (count != `RW_FIFO_CNT_WIDTH'(`RW_FIFO_DEPTH));
  assign word_hs    = tvalid && tready;
  assign push       = word_hs && half_valid;  // Second word completes a beat
  assign pop        = beat_valid && beat_ready;
  assign beat_valid = (count != '0);
  assign beat       = mem[rd_ptr];
  assign beat_count = count;

  always_ff @(posedge aclk)
  begin
    if (push)
    begin
      mem[wr_ptr] <= {tdata, half_q};  // Lower half holds the earlier word
    end
  end

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      half_valid <= 1'b0;
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
    end
    else
    begin
      if (word_hs)
      begin
        half_valid <= !half_valid;
      end
      if (push)
      begin
        wr_ptr <= wr_ptr + 1'b1;  // Depth is a power of two, wraps naturally
      end
      if (pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      count <= count + (push ? 1'b1 : 1'b0) - (pop ? 1'b1 : 1'b0);
    end
  end

  always_ff @(posedge aclk)
  begin
    if (word_hs && !half_valid)
    begin
      half_q <= tdata;
    end
  end

endmodule

/* axis_ram_writer.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module axis_ram_writer (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  ram_writer_pkg::rw_cfg_t       cfg,
  input  logic [`RW_AXI_DATA_WIDTH-1:0] beat,
  input  logic                          beat_valid,
  input  logic [`RW_FIFO_CNT_WIDTH-1:0] beat_count,
  output logic                          beat_ready,
  output ram_writer_pkg::axi_aw_t       aw,
  output logic                          awvalid,
  input  logic                          awready,
  output ram_writer_pkg::axi_w_t        w,
  output logic                          wvalid,
  input  logic                          wready,
  input  ram_writer_pkg::axi_b_t        b,
  input  logic                          bvalid,
  output logic                          bready,
  output ram_writer_pkg::rw_status_t    status
);

  import ram_writer_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ADDR_DATA,
    RESP
  } state_t;

  state_t      state;
  logic [3:0]  beat_idx;   // Beat number within the burst
  logic        w_active;   // W beats still owed
  logic [31:0] offset;
  logic [31:0] offset_next;
  logic [31:0] ptr;
  logic [31:0] err_count;
  logic        enable_q;
  logic        w_hs;
  logic        w_last_hs;
  logic        aw_done;

  // AW payload is fixed apart from the address
  assign aw.id    = '0;
  assign aw.addr  = cfg.base + offset;
  assign aw.len   = 8'(`RW_BURST_LEN - 1);
  assign aw.size  = `RW_AXI_SIZE;
  assign aw.burst = 2'b01;  // INCR
  assign aw.cache = 4'b0001;
  assign aw.prot  = 3'd0;

  // W beats come straight out of the FIFO
  assign w.data     = beat;
  assign w.strb     = '1;
  assign w.last     = (beat_idx == 4'(`RW_BURST_LEN - 1));
  assign wvalid     = (state == ADDR_DATA) && w_active && beat_valid;
  assign beat_ready = (state == ADDR_DATA) && w_active && wready;
  assign w_hs       = wvalid && wready;
  assign w_last_hs  = w_hs && w.last;
  assign aw_done    = !awvalid || awready;
  assign bready     = (state == RESP);

  assign offset_next = (offset + 32'(`RW_BURST_BYTES) >= cfg.size) ? 32'd0
                                                                    : offset + 32'(`RW_BURST_BYTES);

  assign status.ptr       = ptr;
  assign status.err_count = err_count;

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      state     <= IDLE;
      awvalid   <= 1'b0;
      w_active  <= 1'b0;
      beat_idx  <= '0;
      offset    <= '0;
      ptr       <= '0;
      err_count <= '0;
      enable_q  <= 1'b0;
    end
    else
    begin
      enable_q <= cfg.enable;
      case (state)
        IDLE:
        begin
          if (cfg.enable && beat_count >= `RW_FIFO_CNT_WIDTH'(`RW_BURST_LEN))
          begin
            state    <= ADDR_DATA;
            awvalid  <= 1'b1;
            w_active <= 1'b1;
            beat_idx <= '0;
          end
        end
        ADDR_DATA:
        begin
          if (awvalid && awready)
          begin
            awvalid <= 1'b0;
          end
          if (w_hs)
          begin
            beat_idx <= beat_idx + 1'b1;
          end
          if (w_last_hs)
          begin
            w_active <= 1'b0;
          end
          if (aw_done && (!w_active || w_last_hs))
          begin
            state <= RESP;  // Both address and data sent
          end
        end
        RESP:
        begin
          if (bvalid)
          begin
            state  <= IDLE;
            offset <= offset_next;
            ptr    <= offset_next;
            if (b.resp != RESP_OKAY)
            begin
              err_count <= err_count + 1'b1;
            end
          end
        end
        default:
        begin
          state <= IDLE;
        end
      endcase
      // Re-enable restarts the ring from its base
      if (cfg.enable && !enable_q)
      begin
        offset <= '0;
        ptr    <= '0;
      end
    end
  end

endmodule

/* ram_writer_regs.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module ram_writer_regs (
  input  logic                        aclk,
  input  logic                        aresetn,
  input  ram_writer_pkg::lite_aw_t    aw,
  input  logic                        awvalid,
  output logic                        awready,
  input  ram_writer_pkg::lite_w_t     w,
  input  logic                        wvalid,
  output logic                        wready,
  output logic [1:0]                  bresp,
  output logic                        bvalid,
  input  logic                        bready,
  input  ram_writer_pkg::lite_ar_t    ar,
  input  logic                        arvalid,
  output logic                        arready,
  output ram_writer_pkg::lite_r_t     r,
  output logic                        rvalid,
  input  logic                        rready,
  output ram_writer_pkg::rw_cfg_t     cfg,
  input  ram_writer_pkg::rw_status_t  status
);

  import ram_writer_pkg::*;

  logic                           wr_hs;
  logic                           rd_hs;
  logic [`RW_LITE_ADDR_WIDTH-1:0] wr_addr;
  logic [`RW_LITE_ADDR_WIDTH-1:0] rd_addr;

  function automatic logic [31:0] apply_strb(input logic [31:0] old_val,
                                             input logic [31:0] new_val,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_val;
    for (int i = 0; i < 4; i++)
    begin
      if (strb[i])
      begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  // Address and data are taken in the same cycle
  assign awready = awvalid && wvalid && !bvalid;
  assign wready  = awready;
  assign wr_hs   = awready;
  assign arready = !rvalid;
  assign rd_hs   = arvalid && arready;
  assign wr_addr = {aw.addr[`RW_LITE_ADDR_WIDTH-1:2], 2'b00};  // Word aligned
  assign rd_addr = {ar.addr[`RW_LITE_ADDR_WIDTH-1:2], 2'b00};

  always_ff @(posedge aclk)
  begin
    if (!aresetn)
    begin
      cfg    <= '0;
      bvalid <= 1'b0;
      bresp  <= RESP_OKAY;
      rvalid <= 1'b0;
      r      <= '0;
    end
    else
    begin
      if (bvalid && bready)
      begin
        bvalid <= 1'b0;
      end
      if (wr_hs)
      begin
        bvalid <= 1'b1;
        bresp  <= RESP_OKAY;
        case (wr_addr)
          `RW_REG_CTRL: cfg.enable <= w.strb[0] ? w.data[0] : cfg.enable;
          `RW_REG_BASE: cfg.base   <= apply_strb(cfg.base, w.data, w.strb);
          `RW_REG_SIZE: cfg.size   <= apply_strb(cfg.size, w.data, w.strb);
          default:      bresp      <= RESP_SLVERR;  // Status or unmapped
        endcase
      end
      if (rvalid && rready)
      begin
        rvalid <= 1'b0;
      end
      if (rd_hs)
      begin
        rvalid <= 1'b1;
        r.resp <= RESP_OKAY;
        case (rd_addr)
          `RW_REG_CTRL: r.data <= {31'd0, cfg.enable};
          `RW_REG_BASE: r.data <= cfg.base;
          `RW_REG_SIZE: r.data <= cfg.size;
          `RW_REG_PTR:  r.data <= status.ptr;
          `RW_REG_ERR:  r.data <= status.err_count;
          default:
          begin
            r.data <= '0;
            r.resp <= RESP_SLVERR;
          end
        endcase
      end
    end
  end

endmodule

/* ram_writer_top.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module ram_writer_top (
  input  logic                       aclk,
  input  logic                       aresetn,
  input  logic [`RW_AXIS_WIDTH-1:0]  s_axis_tdata,
  input  logic                       s_axis_tvalid,
  output logic                       s_axis_tready,
  output ram_writer_pkg::axi_aw_t    m_axi_aw,
  output logic                       m_axi_awvalid,
  input  logic                       m_axi_awready,
  output ram_writer_pkg::axi_w_t     m_axi_w,
  output logic                       m_axi_wvalid,
  input  logic                       m_axi_wready,
  input  ram_writer_pkg::axi_b_t     m_axi_b,
  input  logic                       m_axi_bvalid,
  output logic                       m_axi_bready,
  input  ram_writer_pkg::lite_aw_t   s_lite_aw,
  input  logic                       s_lite_awvalid,
  output logic                       s_lite_awready,
  input  ram_writer_pkg::lite_w_t    s_lite_w,
  input  logic                       s_lite_wvalid,
  output logic                       s_lite_wready,
  output logic [1:0]                 s_lite_bresp,
  output logic                       s_lite_bvalid,
  input  logic                       s_lite_bready,
  input  ram_writer_pkg::lite_ar_t   s_lite_ar,
  input  logic                       s_lite_arvalid,
  output logic                       s_lite_arready,
  output ram_writer_pkg::lite_r_t    s_lite_r,
  output logic                       s_lite_rvalid,
  input  logic                       s_lite_rready
);

  import ram_writer_pkg::*;

  rw_cfg_t                       cfg;
  rw_status_t                    status;
  logic [`RW_AXI_DATA_WIDTH-1:0] beat;
  logic                          beat_valid;
  logic                          beat_ready;
  logic [`RW_FIFO_CNT_WIDTH-1:0] beat_count;

  axis_pack_fifo axis_pack_fifo_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg        (cfg),
    .tdata      (s_axis_tdata),
    .tvalid     (s_axis_tvalid),
    .tready     (s_axis_tready),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .beat_count (beat_count)
  );

  axis_ram_writer axis_ram_writer_inst (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .cfg        (cfg),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_count (beat_count),
    .beat_ready (beat_ready),
    .aw         (m_axi_aw),
    .awvalid    (m_axi_awvalid),
    .awready    (m_axi_awready),
    .w          (m_axi_w),
    .wvalid     (m_axi_wvalid),
    .wready     (m_axi_wready),
    .b          (m_axi_b),
    .bvalid     (m_axi_bvalid),
    .bready     (m_axi_bready),
    .status     (status)
  );

  ram_writer_regs ram_writer_regs_inst (
    .aclk    (aclk),
    .aresetn (aresetn),
    .aw      (s_lite_aw),
    .awvalid (s_lite_awvalid),
    .awready (s_lite_awready),
    .w       (s_lite_w),
    .wvalid  (s_lite_wvalid),
    .wready  (s_lite_wready),
    .bresp   (s_lite_bresp),
    .bvalid  (s_lite_bvalid),
    .bready  (s_lite_bready),
    .ar      (s_lite_ar),
    .arvalid (s_lite_arvalid),
    .arready (s_lite_arready),
    .r       (s_lite_r),
    .rvalid  (s_lite_rvalid),
    .rready  (s_lite_rready),
    .cfg     (cfg),
    .status  (status)
  );

endmodule

/* tb_axi_ram.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module tb_axi_ram (
  input  logic                          aclk,
  input  logic                          aresetn,
  input  ram_writer_pkg::axi_aw_t       aw,
  input  logic                          awvalid,
  output logic                          awready,
  input  ram_writer_pkg::axi_w_t        w,
  input  logic                          wvalid,
  output logic                          wready,
  output ram_writer_pkg::axi_b_t        b,
  output logic                          bvalid,
  input  logic                          bready,
  input  logic                          stall_en,  // Random awready and wready
  input  logic [`RW_AXI_ADDR_WIDTH-1:0] err_lo,
  input  logic [`RW_AXI_ADDR_WIDTH-1:0] err_hi
);

  import ram_writer_pkg::*;

  // Keyed by the byte address of each beat
  logic [`RW_AXI_DATA_WIDTH-1:0] mem [logic [`RW_AXI_ADDR_WIDTH-1:0]];
  logic [`RW_AXI_ADDR_WIDTH-1:0] burst_start;
  logic [`RW_AXI_ADDR_WIDTH-1:0] beat_addr;
  logic [`RW_AXI_DATA_WIDTH-1:0] beat_data;
  logic                          have_aw;       // One burst at a time
  logic                          resp_pending;
  logic [31:0]                   rnd;
  integer                        seed = 32'ha626_4c61;

  function automatic logic [`RW_AXI_DATA_WIDTH-1:0] peek(
    input logic [`RW_AXI_ADDR_WIDTH-1:0] addr);
    if (mem.exists(addr))
    begin
      return mem[addr];
    end
    return '0;  // Never written
  endfunction

  always @(posedge aclk)
  begin
    if (!aresetn)
    begin
      have_aw      = 1'b0;
      resp_pending = 1'b0;
      burst_start  = '0;
    end
    else
    begin
      if (awvalid && awready)
      begin
        have_aw     = 1'b1;
        burst_start = aw.addr;
        beat_addr   = aw.addr;
      end
      if (wvalid && wready)
      begin
        beat_data = peek(beat_addr);
        for (int i = 0; i < `RW_AXI_STRB_WIDTH; i++)
        begin
          if (w.strb[i])
          begin
            beat_data[8*i +: 8] = w.data[8*i +: 8];  // Only enabled byte lanes land
          end
        end
        mem[beat_addr] = beat_data;
        beat_addr      = beat_addr + `RW_AXI_STRB_WIDTH;
        if (w.last)
        begin
          resp_pending = 1'b1;
        end
      end
      if (bvalid && bready)
      begin
        resp_pending = 1'b0;
        have_aw      = 1'b0;
      end
    end
  end

  // Responses change on the falling edge only
  initial
  begin
    awready = 1'b0;
    wready  = 1'b0;
    bvalid  = 1'b0;
    b       = '0;
    forever
    begin
      @(negedge aclk);
      rnd = stall_en ? $random(seed) : 32'hffff_ffff;
      if (!aresetn)
      begin
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
        b       <= '0;
      end
      else
      begin
        awready <= !have_aw && rnd[0];
        wready  <= have_aw && !resp_pending && rnd[1];
        bvalid  <= resp_pending;
        b.id    <= '0;
        b.resp  <= (burst_start >= err_lo && burst_start < err_hi) ? RESP_SLVERR : RESP_OKAY;
      end
    end
  end

endmodule

/* ram_writer_tb.sv */
`timescale 1ns/1ps
`include "ram_writer_defines.svh"

module ram_writer_tb;

  import ram_writer_pkg::*;

  localparam int WAIT_LIMIT = 5000;  // Cycles per wait

  logic                          aclk;
  logic                          aresetn;
  logic [`RW_AXIS_WIDTH-1:0]     s_axis_tdata;
  logic                          s_axis_tvalid;
  logic                          s_axis_tready;
  axi_aw_t                       m_axi_aw;
  logic                          m_axi_awvalid;
  logic                          m_axi_awready;
  axi_w_t                        m_axi_w;
  logic                          m_axi_wvalid;
  logic                          m_axi_wready;
  axi_b_t                        m_axi_b;
  logic                          m_axi_bvalid;
  logic                          m_axi_bready;
  lite_aw_t                      s_lite_aw;
  logic                          s_lite_awvalid;
  logic                          s_lite_awready;
  lite_w_t                       s_lite_w;
  logic                          s_lite_wvalid;
  logic                          s_lite_wready;
  logic [1:0]                    s_lite_bresp;
  logic                          s_lite_bvalid;
  logic                          s_lite_bready;
  lite_ar_t                      s_lite_ar;
  logic                          s_lite_arvalid;
  logic                          s_lite_arready;
  lite_r_t                       s_lite_r;
  logic                          s_lite_rvalid;
  logic                          s_lite_rready;
  logic                          stall_en;
  logic [`RW_AXI_ADDR_WIDTH-1:0] err_lo;
  logic [`RW_AXI_ADDR_WIDTH-1:0] err_hi;

  string       test_name;
  int          test_errors   = 0;
  int          checks_failed = 0;
  int          tests_run     = 0;
  int          tests_failed  = 0;
  int          timeouts      = 0;
  int          bursts_done   = 0;  // B handshakes seen
  event        compare_req;
  logic        compare_busy;
  int          cmp_tag;
  int          cmp_words;
  int          cmp_size;
  int          cmp_skip_lo;
  int          cmp_skip_hi;
  logic [31:0] cmp_base;

  always #5 aclk = ~aclk;

  ram_writer_top ram_writer_top_inst (.*);

  tb_axi_ram ram_inst (
    .aclk     (aclk),
    .aresetn  (aresetn),
    .aw       (m_axi_aw),
    .awvalid  (m_axi_awvalid),
    .awready  (m_axi_awready),
    .w        (m_axi_w),
    .wvalid   (m_axi_wvalid),
    .wready   (m_axi_wready),
    .b        (m_axi_b),
    .bvalid   (m_axi_bvalid),
    .bready   (m_axi_bready),
    .stall_en (stall_en),
    .err_lo   (err_lo),
    .err_hi   (err_hi)
  );

  always @(posedge aclk)
  begin
    if (m_axi_awvalid && m_axi_awready)
    begin
      check_aw("write address len/size/burst", burst_shape(), m_axi_aw);
    end
    if (m_axi_bvalid && m_axi_bready)
    begin
      bursts_done <= bursts_done + 1;
    end
  end

  function automatic logic [`RW_AXIS_WIDTH-1:0] stream_word(input int tag, input int k);
    return {8'(tag), 24'(k)};
  endfunction

  // Word k sits at base + (4k mod size), later words overwrite earlier ones
  function automatic logic [`RW_AXI_DATA_WIDTH-1:0] expected_beat(input int tag, input int words,
                                                                  input int size, input int offset);
    logic [`RW_AXIS_WIDTH-1:0] lo;
    logic [`RW_AXIS_WIDTH-1:0] hi;
    int                        pos;
    lo = '0;
    hi = '0;
    for (int k = 0; k < words; k++)
    begin
      pos = (4 * k) % size;
      if (pos == offset)
      begin
        lo = stream_word(tag, k);
      end
      if (pos == offset + 4)
      begin
        hi = stream_word(tag, k);
      end
    end
    return {hi, lo};
  endfunction

  // Every burst is an INCR burst of 16 beats, 8 bytes each
  function automatic axi_aw_t burst_shape();
    axi_aw_t shape;
    shape       = '0;
    shape.len   = 8'd15;
    shape.size  = 3'd3;
    shape.burst = 2'b01;
    return shape;
  endfunction

  task automatic check_word(input string what, input logic [`RW_AXI_DATA_WIDTH-1:0] expected,
                            input logic [`RW_AXI_DATA_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_reg(input string what, input logic [`RW_LITE_DATA_WIDTH-1:0] expected,
                           input logic [`RW_LITE_DATA_WIDTH-1:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: %s expected %h actual %h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_resp(input string what, input logic [1:0] expected,
                            input logic [1:0] actual);
    if (actual !== expected)
    begin
      $display("ERROR %s: %s expected %0d actual %0d", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_aw(input string what, input axi_aw_t expected, input axi_aw_t actual);
    if ({actual.len, actual.size, actual.burst} !== {expected.len, expected.size, expected.burst})
    begin
      $display("ERROR %s: %s expected %h/%h/%h actual %h/%h/%h", test_name, what,
               expected.len, expected.size, expected.burst,
               actual.len, actual.size, actual.burst);
      test_errors++;
    end
  endtask

  task automatic note_timeout(input string what);
    if (timeouts == 0)
    begin
      $display("Test %s gave up waiting for %s", test_name, what);
    end
    timeouts++;
    test_errors++;
  endtask

  // Walks the ring and checks every beat outside the skipped offsets
  always @(compare_req)
  begin : compare_mem
    int span;
    span = (cmp_words * 4 < cmp_size) ? cmp_words * 4 : cmp_size;
    for (int off = 0; off < span; off += 8)
    begin
      if (off < cmp_skip_lo || off >= cmp_skip_hi)
      begin
        check_word($sformatf("beat at %h", cmp_base + 32'(off)),
                   expected_beat(cmp_tag, cmp_words, cmp_size, off),
                   ram_inst.peek(cmp_base + 32'(off)));
      end
    end
    compare_busy = 1'b0;
  end

  task automatic lite_write(input logic [`RW_LITE_ADDR_WIDTH-1:0] addr,
                            input logic [`RW_LITE_DATA_WIDTH-1:0] data, output logic [1:0] resp);
    int   n;
    logic got;
    @(negedge aclk);
    s_lite_aw.addr = addr;
    s_lite_w.data  = data;
    s_lite_w.strb  = 4'hf;
    s_lite_awvalid = 1'b1;
    s_lite_wvalid  = 1'b1;
    n   = 0;
    got = 1'b0;
    while (!got && n < WAIT_LIMIT && timeouts == 0)
    begin
      @(posedge aclk);
      got = s_lite_awready;
      n++;
    end
    if (!got) note_timeout("lite write handshake");
    @(negedge aclk);
    s_lite_awvalid = 1'b0;
    s_lite_wvalid  = 1'b0;
    n   = 0;
    got = 1'b0;
    resp = 2'b11;
    while (!got && n < WAIT_LIMIT && timeouts == 0)
    begin
      @(posedge aclk);
      got  = s_lite_bvalid;
      resp = s_lite_bresp;  // bready is tied high
      n++;
    end
    if (!got) note_timeout("lite write response");
  endtask

  task automatic lite_read(input logic [`RW_LITE_ADDR_WIDTH-1:0] addr,
                           output logic [`RW_LITE_DATA_WIDTH-1:0] data, output logic [1:0] resp);
    int   n;
    logic got;
    @(negedge aclk);
    s_lite_ar.addr = addr;
    s_lite_arvalid = 1'b1;
    n   = 0;
    got = 1'b0;
    while (!got && n < WAIT_LIMIT && timeouts == 0)
    begin
      @(posedge aclk);
      got = s_lite_arready;
      n++;
    end
    if (!got) note_timeout("lite read address");
    @(negedge aclk);
    s_lite_arvalid = 1'b0;
    n   = 0;
    got = 1'b0;
    data = '0;
    resp = 2'b11;
    while (!got && n < WAIT_LIMIT && timeouts == 0)
    begin
      @(posedge aclk);
      got  = s_lite_rvalid;
      data = s_lite_r.data;
      resp = s_lite_r.resp;
      n++;
    end
    if (!got) note_timeout("lite read data");
  endtask

  task automatic read_check(input logic [`RW_LITE_ADDR_WIDTH-1:0] addr, input string what,
                            input logic [`RW_LITE_DATA_WIDTH-1:0] expected);
    logic [`RW_LITE_DATA_WIDTH-1:0] data;
    logic [1:0]                     resp;
    lite_read(addr, data, resp);
    check_resp({what, " read resp"}, RESP_OKAY, resp);
    check_reg(what, expected, data);
  endtask

  task automatic configure(input logic [31:0] base, input logic [31:0] size);
    logic [1:0] resp;
    lite_write(`RW_REG_CTRL, 32'd0, resp);
    lite_write(`RW_REG_BASE, base, resp);
    check_resp("base write", RESP_OKAY, resp);
    lite_write(`RW_REG_SIZE, size, resp);
    check_resp("size write", RESP_OKAY, resp);
    lite_write(`RW_REG_CTRL, 32'd1, resp);  // Rising enable restarts the ring
    check_resp("enable write", RESP_OKAY, resp);
  endtask

  task automatic send_words(input int tag, input int first, input int count);
    int   n;
    logic got;
    for (int k = first; k < first + count; k++)
    begin
      @(negedge aclk);
      s_axis_tdata  = stream_word(tag, k);
      s_axis_tvalid = 1'b1;
      n   = 0;
      got = 1'b0;
      while (!got && n < WAIT_LIMIT && timeouts == 0)
      begin
        @(posedge aclk);
        got = s_axis_tready;
        n++;
      end
      if (!got) note_timeout("stream tready");
    end
    @(negedge aclk);
    s_axis_tvalid = 1'b0;
  endtask

  task automatic wait_bursts(input int target);
    int n;
    n = 0;
    while (bursts_done < target && n < WAIT_LIMIT && timeouts == 0)
    begin
      @(posedge aclk);
      n++;
    end
    if (bursts_done < target) note_timeout("burst responses");
  endtask

  task automatic compare_ring(input int tag, input int words, input logic [31:0] base,
                              input int size, input int skip_lo, input int skip_hi);
    int n;
    cmp_tag      = tag;
    cmp_words    = words;
    cmp_base     = base;
    cmp_size     = size;
    cmp_skip_lo  = skip_lo;
    cmp_skip_hi  = skip_hi;
    compare_busy = 1'b1;
    -> compare_req;
    n = 0;
    while (compare_busy && n < WAIT_LIMIT)
    begin
      @(posedge aclk);
      n++;
    end
    if (compare_busy) note_timeout("memory compare");
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
    tests_run++;
  endtask

  task automatic finish_test();
    if (test_errors == 0)
    begin
      $display("PASS %s", test_name);
    end
    else
    begin
      $display("FAIL %s with %0d errors", test_name, test_errors);
      tests_failed++;
      checks_failed += test_errors;
    end
  endtask

  // Runs a full-burst stream through a ring and checks memory and ptr
  task automatic ring_test(input string name, input int tag, input logic [31:0] base,
                           input int size, input int words);
    int first_burst;
    start_test(name);
    first_burst = bursts_done;
    configure(base, 32'(size));
    send_words(tag, 0, words);
    wait_bursts(first_burst + words / (2 * `RW_BURST_LEN));
    compare_ring(tag, words, base, size, 0, 0);
    read_check(`RW_REG_PTR, "ptr", 32'((4 * words) % size));
    finish_test();
  endtask

  initial
  begin
    logic [`RW_LITE_DATA_WIDTH-1:0] data;
    logic [1:0]                     resp;
    int                             mark;
    aclk           = 1'b0;
    aresetn        = 1'b0;
    s_axis_tdata   = '0;
    s_axis_tvalid  = 1'b0;
    s_lite_aw      = '0;
    s_lite_awvalid = 1'b0;
    s_lite_w       = '0;
    s_lite_wvalid  = 1'b0;
    s_lite_bready  = 1'b1;
    s_lite_ar      = '0;
    s_lite_arvalid = 1'b0;
    s_lite_rready  = 1'b1;
    stall_en       = 1'b0;
    err_lo         = '0;
    err_hi         = '0;
    compare_busy   = 1'b0;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;

    start_test("registers");
    read_check(`RW_REG_PTR, "ptr after reset", 32'd0);
    read_check(`RW_REG_ERR, "err_count after reset", 32'd0);
    lite_write(`RW_REG_BASE, 32'h1234_5678, resp);
    check_resp("base write", RESP_OKAY, resp);
    read_check(`RW_REG_BASE, "base", 32'h1234_5678);
    lite_write(`RW_REG_SIZE, 32'h0000_0400, resp);
    read_check(`RW_REG_SIZE, "size", 32'h0000_0400);
    lite_write(`RW_REG_CTRL, 32'd1, resp);
    read_check(`RW_REG_CTRL, "ctrl set", 32'd1);
    lite_write(`RW_REG_CTRL, 32'd0, resp);
    read_check(`RW_REG_CTRL, "ctrl clear", 32'd0);
    lite_read(5'h14, data, resp);
    check_resp("unmapped read", RESP_SLVERR, resp);
    lite_write(`RW_REG_PTR, 32'd1, resp);
    check_resp("ptr write", RESP_SLVERR, resp);
    finish_test();

    ring_test("linear", 2, 32'h0001_0000, 4096, 96);
    ring_test("wrap", 3, 32'h0002_0000, 256, 160);
    start_test("wrap bound");
    check_word("beat past ring end", '0, ram_inst.peek(32'h0002_0100));
    finish_test();

    start_test("disable");
    mark = bursts_done;
    configure(32'h0003_0000, 32'h1000);
    read_check(`RW_REG_PTR, "ptr after re-enable", 32'd0);  // Previous ring stopped at 128
    send_words(4, 0, 31);
    fork  // Last word of the burst and the disable share one edge
      send_words(4, 31, 1);
      lite_write(`RW_REG_CTRL, 32'd0, resp);
    join
    check_resp("disable write", RESP_OKAY, resp);
    @(negedge aclk);
    s_axis_tdata  = stream_word(4, 32);
    s_axis_tvalid = 1'b1;  // A whole burst waits in the FIFO meanwhile
    for (int i = 0; i < 20; i++)
    begin
      @(posedge aclk);
      if (s_axis_tready || m_axi_awvalid)
      begin
        $display("Test %s saw tready or awvalid high while disabled", test_name);
        test_errors++;
      end
    end
    @(negedge aclk);
    s_axis_tvalid = 1'b0;
    lite_write(`RW_REG_CTRL, 32'd1, resp);
    check_resp("enable write", RESP_OKAY, resp);
    send_words(4, 32, 32);
    wait_bursts(mark + 2);
    compare_ring(4, 64, 32'h0003_0000, 4096, 0, 0);
    finish_test();

    start_test("error responses");
    err_lo = 32'h0004_0080;  // Second and third bursts
    err_hi = 32'h0004_0180;
    mark   = bursts_done;
    configure(32'h0004_0000, 32'h1000);
    send_words(5, 0, 128);
    wait_bursts(mark + 4);
    read_check(`RW_REG_ERR, "err_count", 32'd2);
    compare_ring(5, 128, 32'h0004_0000, 4096, 128, 384);
    err_lo = '0;
    err_hi = '0;
    finish_test();

    stall_en = 1'b1;
    ring_test("random stalls", 6, 32'h0005_0000, 4096, 192);
    stall_en = 1'b0;

    $display("Tests run %0d, failed %0d, errors %0d, timeouts %0d",
             tests_run, tests_failed, checks_failed, timeouts);
    if (tests_failed == 0)
    begin
      $display("All tests passed");
    end
    else
    begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* ram_writer_top.f */
+incdir+.
ram_writer_pkg.sv
axis_pack_fifo.sv
axis_ram_writer.sv
ram_writer_regs.sv
ram_writer_top.sv
tb_axi_ram.sv
ram_writer_tb.sv

/* Makefile */
TOP = ram_writer_tb

sim:
	verilator --binary --timing -Wno-fatal -f ram_writer_top.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
